// ==== rtl/kernel_ctrl_pkg.sv ====
`default_nettype none

package kernel_ctrl_pkg;

  ////////////////////
  // Bus and word sizes
  ////////////////////

  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 32;
  localparam int STATE_NUM = 4;   // External status words
  localparam int CMD_W     = 8;   // Command field of the opcode word

  ////////////////////
  // Register bank
  ////////////////////

  localparam int ARG_NUM  = 8;
  localparam int IDX_W    = 3;    // Enough for ARG_NUM entries
  localparam int ADDR_LSB = 2;    // Byte offset inside a word

  localparam logic [IDX_W-1:0] REG_CMD        = 3'd0;  // Write starts a command
  localparam logic [IDX_W-1:0] REG_OPCODE     = 3'd1;
  localparam logic [IDX_W-1:0] REG_DATA0      = 3'd2;
  localparam logic [IDX_W-1:0] REG_DATA1      = 3'd3;
  localparam logic [IDX_W-1:0] REG_DELAY      = 3'd4;  // Cycles before the command issues
  localparam logic [IDX_W-1:0] REG_WDT_CLEAR  = 3'd5;  // Bit 0 only
  localparam logic [IDX_W-1:0] REG_WDT_ENABLE = 3'd6;  // Bit 0 only

  // Index 7 is a spare argument word

  localparam logic [WORD_W-1:0] CMD_RESET_VALUE = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// ==== rtl/axil_reg_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slave (
  input  wire                                                             clk,
  input  wire                                                             rstn,

  input  wire  [kernel_ctrl_pkg::ADDR_W-1:0]                              awaddr_i,
  input  wire                                                             awvalid_i,
  output logic                                                            awready_o,
  input  wire  [kernel_ctrl_pkg::WORD_W-1:0]                              wdata_i,
  input  wire                                                             wvalid_i,
  output logic                                                            wready_o,
  output logic                                                            bvalid_o,
  input  wire                                                             bready_i,
  input  wire  [kernel_ctrl_pkg::ADDR_W-1:0]                              araddr_i,
  input  wire                                                             arvalid_i,
  output logic                                                            arready_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              rdata_o,
  output logic                                                            rvalid_o,
  input  wire                                                             rready_i,

  input  wire logic [kernel_ctrl_pkg::STATE_NUM-1:0][kernel_ctrl_pkg::WORD_W-1:0] state_i,

  output logic                                                            cmd_new_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              opcode_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              data0_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              data1_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              delay_o,
  output logic                                                            wdt_clear_o,
  output logic                                                            wdt_enable_o
);

  import kernel_ctrl_pkg::*;

  logic [ARG_NUM-1:0][WORD_W-1:0] args;

  logic [IDX_W-1:0]  rd_idx;
  logic [WORD_W-1:0] rd_word;

  logic [IDX_W-1:0]  wr_idx;
  logic [WORD_W-1:0] wr_data;
  logic              aw_got;
  logic              w_got;
  logic              wr_commit;

  ////////////////////
  // Read channel
  ////////////////////

  assign rd_idx = araddr_i[ADDR_LSB +: IDX_W];

  // Status view of the bank
  always_comb begin
    case (rd_idx)
      REG_CMD:                                    rd_word = args[REG_CMD];
      REG_OPCODE, REG_DATA0, REG_DATA1, REG_DELAY: rd_word = state_i[rd_idx - REG_OPCODE];
      IDX_W'(ARG_NUM - 1):                        rd_word = args[ARG_NUM-1];
      default:                                    rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arready_o <= 1'b1;
      rvalid_o  <= 1'b0;
    end else if (arready_o && arvalid_i) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b1;
    end else if (rvalid_o && rready_i) begin
      rvalid_o  <= 1'b0;
      arready_o <= 1'b1;  // Idle again next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (arready_o && arvalid_i) begin
      rdata_o <= rd_word;  // Held until rready_i
    end
  end

  ////////////////////
  // Write channel
  ////////////////////

  assign wr_commit = aw_got && w_got;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      awready_o <= 1'b1;
      wready_o  <= 1'b1;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      bvalid_o  <= 1'b0;
      cmd_new_o <= 1'b0;
    end else begin
      cmd_new_o <= 1'b0;
      if (awready_o && awvalid_i) begin
        awready_o <= 1'b0;
        aw_got    <= 1'b1;
      end
      if (wready_o && wvalid_i) begin
        wready_o <= 1'b0;
        w_got    <= 1'b1;
      end
      if (wr_commit) begin
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
        bvalid_o  <= 1'b1;
        cmd_new_o <= (wr_idx == REG_CMD);  // Lines up with first bvalid cycle
      end
      // Both channels stay closed until the response is taken
      if (bvalid_o && bready_i) begin
        bvalid_o  <= 1'b0;
        awready_o <= 1'b1;
        wready_o  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready_o && awvalid_i) begin
      wr_idx <= awaddr_i[ADDR_LSB +: IDX_W];
    end
    if (wready_o && wvalid_i) begin
      wr_data <= wdata_i;
    end
  end

  // Argument bank and watchdog controls
  always_ff @(posedge clk) begin
    if (!rstn) begin
      args          <= '0;
      args[REG_CMD] <= CMD_RESET_VALUE;
      wdt_clear_o   <= 1'b0;
      wdt_enable_o  <= 1'b0;
    end else if (wr_commit) begin
      case (wr_idx)
        REG_WDT_CLEAR:  wdt_clear_o  <= wr_data[0];
        REG_WDT_ENABLE: wdt_enable_o <= wr_data[0];
        default:        args[wr_idx] <= wr_data;
      endcase
    end
  end

  assign opcode_o = args[REG_OPCODE];
  assign data0_o  = args[REG_DATA0];
  assign data1_o  = args[REG_DATA1];
  assign delay_o  = args[REG_DELAY];

endmodule

`default_nettype wire

// ==== rtl/cmd_delay_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_delay_issue (
  input  wire                                clk,
  input  wire                                rstn,

  input  wire                                cmd_new_i,
  input  wire  [kernel_ctrl_pkg::WORD_W-1:0] opcode_i,
  input  wire  [kernel_ctrl_pkg::WORD_W-1:0] data0_i,
  input  wire  [kernel_ctrl_pkg::WORD_W-1:0] data1_i,
  input  wire  [kernel_ctrl_pkg::WORD_W-1:0] delay_i,

  output logic                               cmd_valid_o,
  output logic [kernel_ctrl_pkg::CMD_W-1:0]  cmd_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0] cmd_data0_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0] cmd_data1_o
);

  import kernel_ctrl_pkg::*;

  logic              active;
  logic [WORD_W-1:0] count;

  // Fires in the cycle the countdown reaches zero
  assign cmd_valid_o = active && (count == '0);

  ////////////////////
  // Countdown
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      active <= 1'b0;
      count  <= '0;
    end else if (cmd_new_i) begin
      active <= 1'b1;     // Restarts a running countdown too
      count  <= delay_i;
    end else if (active) begin
      if (count == '0) begin
        active <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (cmd_new_i) begin
      cmd_o       <= opcode_i[CMD_W-1:0];
      cmd_data0_o <= data0_i;
      cmd_data1_o <= data1_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/watchdog_reset.sv ====
`timescale 1ns/1ps
`default_nettype none

module watchdog_reset #(
  parameter int TIMEOUT_CYCLES = 50_000_000,
  parameter int RESET_CYCLES   = 100_000
) (
  input  wire  clk,
  input  wire  rstn,

  input  wire  clear_i,
  input  wire  enable_i,
  input  wire  button_i,

  output logic sys_reset_o
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam int DUR_W = $clog2(RESET_CYCLES + 1);

  logic [CNT_W-1:0] count;
  logic [DUR_W-1:0] pulse_left;
  logic             rst_level;

  ////////////////////
  // Timeout and pulse
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count      <= '0;
      pulse_left <= '0;
      rst_level  <= 1'b0;
    end else begin
      rst_level <= (pulse_left != '0);
      if (pulse_left != '0) begin
        pulse_left <= pulse_left - 1'b1;
        count      <= '0;                 // Frozen while the pulse runs
      end else if (enable_i && !clear_i) begin
        if (count == CNT_W'(TIMEOUT_CYCLES - 1)) begin
          count      <= '0;
          pulse_left <= DUR_W'(RESET_CYCLES);
        end else begin
          count <= count + 1'b1;
        end
      end else begin
        count <= '0;
      end
    end
  end

  // Button overrides at any time
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_reset_o <= 1'b0;
    end else begin
      sys_reset_o <= rst_level | button_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/kernel_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl_top #(
  parameter int TIMEOUT_CYCLES = 50_000_000,
  parameter int RESET_CYCLES   = 100_000
) (
  input  wire                                                             clk,
  input  wire                                                             rstn,

  // AXI-Lite slave port
  input  wire  [kernel_ctrl_pkg::ADDR_W-1:0]                              awaddr_i,
  input  wire                                                             awvalid_i,
  output logic                                                            awready_o,
  input  wire  [kernel_ctrl_pkg::WORD_W-1:0]                              wdata_i,
  input  wire                                                             wvalid_i,
  output logic                                                            wready_o,
  output logic                                                            bvalid_o,
  input  wire                                                             bready_i,
  input  wire  [kernel_ctrl_pkg::ADDR_W-1:0]                              araddr_i,
  input  wire                                                             arvalid_i,
  output logic                                                            arready_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              rdata_o,
  output logic                                                            rvalid_o,
  input  wire                                                             rready_i,

  input  wire logic [kernel_ctrl_pkg::STATE_NUM-1:0][kernel_ctrl_pkg::WORD_W-1:0] state_i,
  input  wire                                                             button_i,

  // Command port
  output logic                                                            cmd_valid_o,
  output logic [kernel_ctrl_pkg::CMD_W-1:0]                               cmd_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              cmd_data0_o,
  output logic [kernel_ctrl_pkg::WORD_W-1:0]                              cmd_data1_o,

  output logic                                                            sys_reset_o
);

  import kernel_ctrl_pkg::*;

  logic              cmd_new;
  logic [WORD_W-1:0] opcode;
  logic [WORD_W-1:0] data0;
  logic [WORD_W-1:0] data1;
  logic [WORD_W-1:0] delay;
  logic              wdt_clear;
  logic              wdt_enable;

  axil_reg_slave u_axil_reg_slave (
    .clk          (clk),
    .rstn         (rstn),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .state_i      (state_i),
    .cmd_new_o    (cmd_new),
    .opcode_o     (opcode),
    .data0_o      (data0),
    .data1_o      (data1),
    .delay_o      (delay),
    .wdt_clear_o  (wdt_clear),
    .wdt_enable_o (wdt_enable)
  );

  cmd_delay_issue u_cmd_delay_issue (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_new_i   (cmd_new),
    .opcode_i    (opcode),
    .data0_i     (data0),
    .data1_i     (data1),
    .delay_i     (delay),
    .cmd_valid_o (cmd_valid_o),
    .cmd_o       (cmd_o),
    .cmd_data0_o (cmd_data0_o),
    .cmd_data1_o (cmd_data1_o)
  );

  watchdog_reset #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .RESET_CYCLES   (RESET_CYCLES)
  ) u_watchdog_reset (
    .clk         (clk),
    .rstn        (rstn),
    .clear_i     (wdt_clear),
    .enable_i    (wdt_enable),
    .button_i    (button_i),
    .sys_reset_o (sys_reset_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_kernel_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kernel_ctrl_top;

  import kernel_ctrl_pkg::*;

  localparam int TIMEOUT_CYCLES = 40;
  localparam int RESET_CYCLES   = 6;
  localparam int QUIET_CYCLES   = 100;  // Window that must stay free of watchdog pulses
  localparam     DATA_FILE      = "testbench/kernel_ctrl_testdata.txt";

  logic                             clk;
  logic                             rstn;
  logic [ADDR_W-1:0]                awaddr_i;
  logic [ADDR_W-1:0]                araddr_i;
  logic [WORD_W-1:0]                wdata_i;
  logic                             awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic                             awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [WORD_W-1:0]                rdata_o;
  logic [STATE_NUM-1:0][WORD_W-1:0] state_i;
  logic                             button_i;
  logic                             cmd_valid_o;
  logic [CMD_W-1:0]                 cmd_o;
  logic [WORD_W-1:0]                cmd_data0_o, cmd_data1_o;
  logic                             sys_reset_o;

  int seed      = 32'h1ae5a2f5;
  int errors    = 0;
  int checks    = 0;
  int cyc       = 0;
  int cyc_limit = 20 * 10;  // Reset and idle checks

  logic [7:0]        op_q[$];
  logic [WORD_W-1:0] addr_q[$], data_q[$], exp_q[$];
  logic [WORD_W-1:0] shadow [ARG_NUM];  // Last value written per index

  int                cmd_pulses = 0;
  int                pulse_cyc;
  logic [CMD_W-1:0]  cmd_seen;
  logic [WORD_W-1:0] data0_seen, data1_seen;
  int                rst_rises = 0;
  int                rst_rise_cyc;
  int                rst_len;
  logic              rst_prev;

  kernel_ctrl_top #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .RESET_CYCLES   (RESET_CYCLES)
  ) u_kernel_ctrl_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > cyc_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cyc_limit);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////
  // Output monitors
  ////////////////////

  always @(negedge clk) begin
    if (rstn && cmd_valid_o) begin
      cmd_pulses++;
      pulse_cyc  = cyc;
      cmd_seen   = cmd_o;
      data0_seen = cmd_data0_o;
      data1_seen = cmd_data1_o;
    end
    if (rstn && sys_reset_o && !rst_prev) begin
      rst_rises++;
      rst_rise_cyc = cyc;
    end
    if (rstn && !sys_reset_o && rst_prev) begin
      rst_len = cyc - rst_rise_cyc;
    end
    rst_prev = sys_reset_o;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic wait_until(input int target);
    while (cyc < target) @(negedge clk);
  endtask

  ////////////////////
  // AXI-Lite transfers
  ////////////////////

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                            output int rise_cyc);
    int   hold;
    logic aw_hs;
    logic w_hs;
    hold      = {$random(seed)} % 6;
    awaddr_i  = addr;
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    while (awvalid_i || wvalid_i) begin
      aw_hs = awready_o && awvalid_i;
      w_hs  = wready_o && wvalid_i;
      @(negedge clk);
      if (aw_hs) awvalid_i = 1'b0;
      if (w_hs) wvalid_i = 1'b0;
    end
    while (!bvalid_o) @(negedge clk);
    rise_cyc = cyc;
    repeat (hold) begin
      @(negedge clk);
      check_value("bvalid_o", 1, bvalid_o);
      check_value("awready_o", 0, awready_o);  // No second write before bready
      check_value("wready_o", 0, wready_o);
    end
    bready_i = 1'b1;
    @(negedge clk);
    bready_i = 1'b0;
    check_value("bvalid_o", 0, bvalid_o);
    check_value("awready_o", 1, awready_o);
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
    int   hold;
    logic ar_hs;
    hold      = {$random(seed)} % 6;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    while (arvalid_i) begin
      ar_hs = arready_o;
      @(negedge clk);
      if (ar_hs) begin
        arvalid_i = 1'b0;
        araddr_i  = ~addr;  // Address may move once accepted
      end
    end
    while (!rvalid_o) @(negedge clk);
    data = rdata_o;
    repeat (hold) begin
      @(negedge clk);
      check_value("rvalid_o", 1, rvalid_o);
      check_value("rdata_o", data, rdata_o);  // Held while rready is low
    end
    rready_i = 1'b1;
    @(negedge clk);
    rready_i = 1'b0;
    check_value("rvalid_o", 0, rvalid_o);
    check_value("arready_o", 1, arready_o);
  endtask

  ////////////////////
  // Test data
  ////////////////////

  function automatic int line_cycles(input logic [7:0] op, input int data, input int exp);
    case (op)
      "C":     return exp + 20;
      "D":     return (exp != 0) ? exp + RESET_CYCLES + 20 : QUIET_CYCLES + 20;
      "B":     return data + 6;
      default: return 15;
    endcase
  endfunction

  task automatic load_testdata();
    int                fd;
    int                n;
    logic [7:0]        op;
    logic [WORD_W-1:0] a, d, e;
    logic [8*128-1:0]  skip;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the test data file %s", DATA_FILE);
    end
    n = (fd == 0) ? -1 : $fscanf(fd, " %c", op);
    while (n == 1) begin
      if (op == "#") begin
        n = $fgets(skip, fd);
      end else if ($fscanf(fd, " %h %h %h", a, d, e) == 3) begin
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
        cyc_limit += 20 * line_cycles(op, d, e);
      end else begin
        errors++;
        $display("malformed line in the test data file after entry %0d", op_q.size());
      end
      n = $fscanf(fd, " %c", op);
    end
    if (fd != 0) $fclose(fd);
  endtask

  initial begin
    logic [WORD_W-1:0] got;
    int                rise;
    int                snap;
    rstn      = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    button_i  = 1'b0;
    state_i   = {32'h5a5a_0004, 32'h5a5a_0003, 32'h5a5a_0002, 32'h5a5a_0001};
    load_testdata();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_value("arready_o", 1, arready_o);
    check_value("awready_o", 1, awready_o);
    check_value("wready_o", 1, wready_o);
    check_value("rvalid_o", 0, rvalid_o);
    check_value("bvalid_o", 0, bvalid_o);
    check_value("cmd_valid_o", 0, cmd_valid_o);
    check_value("sys_reset_o", 0, sys_reset_o);

    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": begin
          axil_write(addr_q[i], data_q[i], rise);
          shadow[addr_q[i][ADDR_LSB +: IDX_W]] = data_q[i];
        end
        "R": begin
          axil_read(addr_q[i], got);
          check_value("rdata_o", exp_q[i], got);
        end
        "C": begin  // Pulse due delay + 1 cycles after bvalid rises
          snap = cmd_pulses;
          axil_write(addr_q[i], data_q[i], rise);
          wait_until(rise + exp_q[i] + 6);
          check_value("cmd_valid_o pulse count", 1, cmd_pulses - snap);
          check_value("cmd_valid_o cycle", rise + exp_q[i] + 1, pulse_cyc);
          check_value("cmd_o", shadow[REG_OPCODE][CMD_W-1:0], cmd_seen);
          check_value("cmd_data0_o", shadow[REG_DATA0], data0_seen);
          check_value("cmd_data1_o", shadow[REG_DATA1], data1_seen);
        end
        "D": begin
          snap = rst_rises;
          axil_write(addr_q[i], data_q[i], rise);
          if (exp_q[i] != 0) begin
            wait_until(rise + exp_q[i] + RESET_CYCLES + 3);
            check_value("sys_reset_o rise count", 1, rst_rises - snap);
            check_value("sys_reset_o rise cycle", rise + exp_q[i], rst_rise_cyc);
            check_value("sys_reset_o pulse length", RESET_CYCLES, rst_len);
          end else begin
            wait_until(rise + QUIET_CYCLES);
            check_value("sys_reset_o rise count", 0, rst_rises - snap);
          end
        end
        "B": begin
          button_i = 1'b1;
          repeat (data_q[i] + 1) begin
            @(negedge clk);
            check_value("sys_reset_o", exp_q[i], sys_reset_o);
          end
          button_i = 1'b0;
          @(negedge clk);
          check_value("sys_reset_o", 0, sys_reset_o);
        end
        default: begin
          errors++;
          $display("unknown operation %c in the test data", op_q[i]);
        end
      endcase
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/kernel_ctrl_testdata.txt ====
# op addr data expected (hex); W write, R read, C command (expected = delay),
# D watchdog (expected = cycles to reset pulse, 0 = none), B button (data = extra hold cycles)
R 00000000 00000000 deadbeef
R 00000014 00000000 00000000
R 00000018 00000000 00000000
R 0000001c 00000000 00000000
R 00000004 00000000 5a5a0001
R 00000008 00000000 5a5a0002
R 0000000c 00000000 5a5a0003
R 00000010 00000000 5a5a0004
W 0000001c 13572468 00000000
R 0000001c 00000000 13572468
W 00000000 0badf00d 00000000
R 00000000 00000000 0badf00d
W 00000004 000001a5 00000000
W 00000008 11112222 00000000
W 0000000c 33334444 00000000
W 00000010 00000000 00000000
C 00000000 00000001 00000000
W 00000004 0000c33c 00000000
W 00000008 55556666 00000000
W 0000000c 77778888 00000000
W 00000010 00000003 00000000
C 00000000 00000002 00000003
W 00000004 ffffff7e 00000000
W 00000008 9999aaaa 00000000
W 0000000c bbbbcccc 00000000
W 00000010 00000009 00000000
C 00000000 00000003 00000009
R 00000000 00000000 00000003
R 00000010 00000000 5a5a0004
R 0000001c 00000000 13572468
D 00000018 00000001 0000002a
D 00000014 00000001 00000000
R 00000014 00000000 00000000
B 00000000 00000003 00000001
W 00000018 00000000 00000000
W 00000014 00000000 00000000
B 00000000 00000000 00000001

// ==== all.f ====
rtl/kernel_ctrl_pkg.sv
rtl/axil_reg_slave.sv
rtl/cmd_delay_issue.sv
rtl/watchdog_reset.sv
rtl/kernel_ctrl_top.sv
testbench/tb_kernel_ctrl_top.sv

// ==== Bender.yml ====
package:
  name: kernel_ctrl

sources:
  - rtl/kernel_ctrl_pkg.sv
  - rtl/axil_reg_slave.sv
  - rtl/cmd_delay_issue.sv
  - rtl/watchdog_reset.sv
  - rtl/kernel_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_kernel_ctrl_top.sv
